// ==== bench/bounce_patterns.hex ====
// one test per line: speed, fill colour index, frame n,
// expected square x and y shown in frame n (all hex)
03 08 0A 0F 09
07 0C 06 07 07
03 02 10 03 09
05 0B 08 05 05
01 0F 04 03 03
07 09 09 0E 00

// ==== bench/bounce_tb.sv ====
/*
 * bouncing square testbench: runs each pattern record, captures
 * whole video frames and checks raster timing, colours and square position
 */
`timescale 1ns/10ps

module bounce_tb;

    localparam int MAX_TESTS = 16;
    localparam int REC_LEN   = 5;  // fields per pattern record

    logic               clk_100m;
    logic               rst_n;
    bounce_pkg::speed_t speed;
    bounce_pkg::cidx_t  fill_cidx;
    bounce_pkg::video_t video;

    logic [7:0]        patterns [MAX_TESTS * REC_LEN];
    bounce_pkg::chan_t cap_r [bounce_pkg::FB_PIXELS];  // one captured frame
    bounce_pkg::chan_t cap_g [bounce_pkg::FB_PIXELS];
    bounce_pkg::chan_t cap_b [bounce_pkg::FB_PIXELS];
    int                errors;
    int                checks;
    int                num_tests;
    longint            limit_ns;

    bounce_top u_dut (
        .clk_100m  (clk_100m),
        .rst_n     (rst_n),
        .speed     (speed),
        .fill_cidx (fill_cidx),
        .video     (video)
    );

    always #5 clk_100m = ~clk_100m;

    task automatic check_rgb(input string name, input bounce_pkg::cidx_t exp_cidx,
                             input bounce_pkg::chan_t red, input bounce_pkg::chan_t green,
                             input bounce_pkg::chan_t blue);
        logic [11:0] exp_rgb;
        exp_rgb = bounce_pkg::PALETTE[exp_cidx];
        checks++;
        if ({red, green, blue} !== exp_rgb) begin
            errors++;
            $display("FAIL %s: expected %03h, actual %03h", name, exp_rgb, {red, green, blue});
        end
    endtask

    task automatic check_count(input string name, input int exp_val, input int act_val);
        checks++;
        if (exp_val != act_val) begin
            errors++;
            $display("FAIL %s: expected %0d, actual %0d", name, exp_val, act_val);
        end
    endtask

    task automatic check_coord(input string name, input bounce_pkg::coord_t exp_val,
                               input bounce_pkg::coord_t act_val);
        checks++;
        if (exp_val !== act_val) begin
            errors++;
            $display("FAIL %s: expected %0d, actual %0d", name, exp_val, act_val);
        end
    endtask

    // position after a number of frame pulses, stepped with the bounce rule
    task automatic model_position(input int s, input int steps, output int x, output int y);
        logic left;
        logic up;
        x    = 0;
        y    = 0;
        left = 1'b0;
        up   = 1'b0;
        for (int k = 0; k < steps; k++) begin
            if (x >= bounce_pkg::FB_WIDTH - (bounce_pkg::SQ_SIZE + s)) begin
                left = 1'b1;
                x    = x - s;
            end else if (x < s) begin
                left = 1'b0;
                x    = x + s;
            end else begin
                x = left ? x - s : x + s;
            end
            if (y >= bounce_pkg::FB_HEIGHT - (bounce_pkg::SQ_SIZE + s)) begin
                up = 1'b1;
                y  = y - s;
            end else if (y < s) begin
                up = 1'b0;
                y  = y + s;
            end else begin
                y = up ? y - s : y + s;
            end
        end
    endtask

    // runs from one video frame pulse to the next
    task automatic measure_frame(input string name);
        int   de_count;
        int   run_len;
        int   runs;
        int   bad_runs;
        int   hs_count;
        int   vs_count;
        int   vs_cycles;
        logic prev_de;
        logic prev_hs;
        logic prev_vs;
        logic last;
        de_count  = 0;
        run_len   = 0;
        runs      = 0;
        bad_runs  = 0;
        hs_count  = 0;
        vs_count  = 0;
        vs_cycles = 0;
        prev_de   = 1'b0;
        prev_hs   = 1'b0;
        prev_vs   = 1'b0;
        last      = 1'b0;
        while (!last) begin
            @(negedge clk_100m);
            if (video.de) begin
                if (de_count < bounce_pkg::FB_PIXELS) begin
                    cap_r[de_count] = video.red;
                    cap_g[de_count] = video.green;
                    cap_b[de_count] = video.blue;
                end
                de_count++;
                run_len++;
            end else if (prev_de) begin  // end of an active line
                runs++;
                if (run_len != bounce_pkg::H_ACTIVE)
                    bad_runs++;
                run_len = 0;
            end
            if (video.hsync && !prev_hs)
                hs_count++;
            if (video.vsync)
                vs_cycles++;
            if (video.vsync && !prev_vs)
                vs_count++;
            prev_de = video.de;
            prev_hs = video.hsync;
            prev_vs = video.vsync;
            last    = video.frame;
        end
        check_count({name, " de cycles"}, bounce_pkg::FB_PIXELS, de_count);
        check_count({name, " de runs"}, bounce_pkg::V_ACTIVE, runs);
        check_count({name, " short de runs"}, 0, bad_runs);
        check_count({name, " hsync pulses"}, bounce_pkg::V_TOTAL, hs_count);
        check_count({name, " vsync pulses"}, 1, vs_count);
        check_count({name, " vsync cycles"},
                    (bounce_pkg::V_SYNC_END - bounce_pkg::V_SYNC_START) * bounce_pkg::H_TOTAL,
                    vs_cycles);
    endtask

    task automatic check_square(input string name, input bounce_pkg::coord_t exp_x,
                                input bounce_pkg::coord_t exp_y, input bounce_pkg::cidx_t fill,
                                output bounce_pkg::coord_t found_x,
                                output bounce_pkg::coord_t found_y);
        int                 ex;
        int                 ey;
        int                 px;
        int                 py;
        int                 sq_count;
        logic               in_box;
        bounce_pkg::coord_t max_x;
        bounce_pkg::coord_t max_y;
        ex       = int'(exp_x);
        ey       = int'(exp_y);
        sq_count = 0;
        found_x  = '1;
        found_y  = '1;
        max_x    = '0;
        max_y    = '0;
        for (int i = 0; i < bounce_pkg::FB_PIXELS; i++) begin
            px     = i % bounce_pkg::FB_WIDTH;
            py     = i / bounce_pkg::FB_WIDTH;
            in_box = (px >= ex) && (px < ex + bounce_pkg::SQ_SIZE)
                  && (py >= ey) && (py < ey + bounce_pkg::SQ_SIZE);
            check_rgb($sformatf("%s pixel (%0d,%0d)", name, px, py),
                      in_box ? fill : bounce_pkg::BG_CIDX, cap_r[i], cap_g[i], cap_b[i]);
            if ({cap_r[i], cap_g[i], cap_b[i]} == bounce_pkg::PALETTE[fill]) begin
                sq_count++;
                if (bounce_pkg::coord_t'(px) < found_x) found_x = bounce_pkg::coord_t'(px);
                if (bounce_pkg::coord_t'(py) < found_y) found_y = bounce_pkg::coord_t'(py);
                if (bounce_pkg::coord_t'(px) > max_x)   max_x = bounce_pkg::coord_t'(px);
                if (bounce_pkg::coord_t'(py) > max_y)   max_y = bounce_pkg::coord_t'(py);
            end
        end
        check_count({name, " square pixels"}, bounce_pkg::SQ_SIZE * bounce_pkg::SQ_SIZE,
                    sq_count);
        check_coord({name, " box x0"}, exp_x, found_x);
        check_coord({name, " box y0"}, exp_y, found_y);
        check_coord({name, " box x1"},
                    exp_x + bounce_pkg::coord_t'(bounce_pkg::SQ_SIZE - 1), max_x);
        check_coord({name, " box y1"},
                    exp_y + bounce_pkg::coord_t'(bounce_pkg::SQ_SIZE - 1), max_y);
    endtask

    task automatic run_test(input int t);
        string              name;
        int                 s;
        int                 n;
        int                 pulses;
        int                 mx;
        int                 my;
        int                 dx;
        int                 dy;
        bounce_pkg::cidx_t  cidx;
        bounce_pkg::coord_t x_a;
        bounce_pkg::coord_t y_a;
        bounce_pkg::coord_t x_b;
        bounce_pkg::coord_t y_b;
        name = $sformatf("test %0d", t);
        s    = int'(patterns[t * REC_LEN]);
        cidx = bounce_pkg::cidx_t'(patterns[t * REC_LEN + 1]);
        n    = int'(patterns[t * REC_LEN + 2]);
        @(negedge clk_100m);
        rst_n     = 1'b0;
        speed     = bounce_pkg::speed_t'(s);
        fill_cidx = cidx;
        repeat (8) @(negedge clk_100m);
        rst_n  = 1'b1;
        pulses = 0;
        while (pulses < n) begin
            @(negedge clk_100m);
            if (video.frame)
                pulses++;
        end
        measure_frame($sformatf("%s frame %0d", name, n));
        check_square($sformatf("%s frame %0d", name, n),
                     bounce_pkg::coord_t'(patterns[t * REC_LEN + 3]),
                     bounce_pkg::coord_t'(patterns[t * REC_LEN + 4]), cidx, x_a, y_a);
        measure_frame($sformatf("%s frame %0d", name, n + 1));
        model_position(s, n, mx, my);  // next frame shows n pulses of motion
        check_square($sformatf("%s frame %0d", name, n + 1), bounce_pkg::coord_t'(mx),
                     bounce_pkg::coord_t'(my), cidx, x_b, y_b);
        dx = int'(x_b) - int'(x_a);
        dy = int'(y_b) - int'(y_a);
        check_count({name, " x step"}, s, (dx < 0) ? -dx : dx);
        check_count({name, " y step"}, s, (dy < 0) ? -dy : dy);
    endtask

    initial begin
        longint frames;
        clk_100m  = 1'b0;
        rst_n     = 1'b0;
        speed     = '0;
        fill_cidx = '0;
        errors    = 0;
        checks    = 0;
        limit_ns  = 0;
        foreach (patterns[i])
            patterns[i] = 8'hFF;  // marks the end of the records
        $readmemh("bench/bounce_patterns.hex", patterns);
        num_tests = 0;
        frames    = 0;
        while (num_tests < MAX_TESTS && patterns[num_tests * REC_LEN] != 8'hFF) begin
            frames = frames + longint'(patterns[num_tests * REC_LEN + 2]) + 3;
            num_tests++;
        end
        if (num_tests == 0) begin
            errors++;
            $display("no test records could be read from the pattern file");
        end
        limit_ns = frames * bounce_pkg::H_TOTAL * bounce_pkg::V_TOTAL * 10 * 2;
        for (int t = 0; t < num_tests; t++)
            run_test(t);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    // watchdog
    initial begin
        wait (limit_ns != 0);
        #(limit_ns);
        $display("timeout: tests were still running after %0d ns", limit_ns);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== project.f ====
verilog/bounce_pkg.sv
verilog/display_timing.sv
verilog/square_motion.sv
verilog/rect_fill.sv
verilog/draw_sequencer.sv
verilog/framebuffer.sv
verilog/bounce_top.sv
bench/bounce_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the bouncing square testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module bounce_tb \
    -f project.f --Mdir obj_dir -o bounce_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/bounce_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

echo "simulation finished without failures"
exit 0

// ==== verilog/bounce_pkg.sv ====
/*
 * bounce package: widths, display and framebuffer sizes,
 * colour palette and the bundles shared between the blocks
 */
package bounce_pkg;

    typedef logic [7:0] coord_t;  // pixel coordinate
    typedef logic [3:0] cidx_t;   // palette index
    typedef logic [3:0] chan_t;   // one colour channel
    typedef logic [2:0] speed_t;  // pixels per frame

    // horizontal timing, in pixels
    localparam int H_ACTIVE     = 32;
    localparam int H_TOTAL      = 40;
    localparam int H_SYNC_START = 34;
    localparam int H_SYNC_END   = 37;

    // vertical timing, in lines
    localparam int V_ACTIVE     = 18;
    localparam int V_TOTAL      = 22;
    localparam int V_SYNC_START = 19;
    localparam int V_SYNC_END   = 20;

    localparam int FB_WIDTH  = 32;
    localparam int FB_HEIGHT = 18;
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;

    localparam int SQ_SIZE = 8;      // square side
    localparam cidx_t BG_CIDX = 4'h0;

    // 16 colours, 4 bits per channel as {red, green, blue}
    localparam logic [11:0] PALETTE [16] = '{
        12'h000, 12'h123, 12'h724, 12'h085,
        12'hA53, 12'h655, 12'hCCC, 12'hFFE,
        12'hF05, 12'hFA0, 12'hFF2, 12'h0E3,
        12'h3AF, 12'h879, 12'hF7A, 12'hFCA
    };

    typedef struct packed {
        logic   hsync;
        logic   vsync;
        logic   de;
        logic   line;   // last cycle of a line
        logic   frame;  // last cycle of a frame
        coord_t sx;
        coord_t sy;
    } sync_t;

    // far corner (x1, y1) is exclusive
    typedef struct packed {
        coord_t x0;
        coord_t y0;
        coord_t x1;
        coord_t y1;
    } rect_t;

    typedef struct packed {
        logic   we;
        coord_t x;
        coord_t y;
        cidx_t  cidx;
    } pix_wr_t;

    typedef struct packed {
        logic  hsync;
        logic  vsync;
        logic  de;
        logic  frame;
        chan_t red;
        chan_t green;
        chan_t blue;
    } video_t;

endpackage

// ==== verilog/bounce_top.sv ====
/*
 * bouncing square top level: timing, motion, draw control,
 * fill engine and double-buffered framebuffer
 */
`timescale 1ns/10ps

module bounce_top (
    input  logic                clk_100m,
    input  logic                rst_n,
    input  bounce_pkg::speed_t  speed,
    input  bounce_pkg::cidx_t   fill_cidx,
    output bounce_pkg::video_t  video
);

    bounce_pkg::sync_t   sync;
    bounce_pkg::coord_t  pos_x;
    bounce_pkg::coord_t  pos_y;
    bounce_pkg::rect_t   rect;
    bounce_pkg::cidx_t   draw_cidx;
    bounce_pkg::pix_wr_t wr;
    logic                wready;
    logic                start;
    logic                fill_done;
    logic                draw_done;

    display_timing u_timing (
        .clk_100m (clk_100m),
        .rst_n    (rst_n),
        .sync     (sync)
    );

    square_motion u_motion (
        .clk_100m (clk_100m),
        .rst_n    (rst_n),
        .frame    (sync.frame),
        .speed    (speed),
        .pos_x    (pos_x),
        .pos_y    (pos_y)
    );

    draw_sequencer u_seq (
        .clk_100m  (clk_100m),
        .rst_n     (rst_n),
        .frame     (sync.frame),
        .wready    (wready),
        .pos_x     (pos_x),
        .pos_y     (pos_y),
        .fill_cidx (fill_cidx),
        .fill_done (fill_done),
        .start     (start),
        .rect      (rect),
        .cidx      (draw_cidx),
        .draw_done (draw_done)
    );

    rect_fill u_fill (
        .clk_100m (clk_100m),
        .rst_n    (rst_n),
        .start    (start),
        .rect     (rect),
        .cidx     (draw_cidx),
        .wr       (wr),
        .done     (fill_done)
    );

    framebuffer u_fb (
        .clk_100m  (clk_100m),
        .rst_n     (rst_n),
        .sync      (sync),
        .wr        (wr),
        .draw_done (draw_done),
        .wready    (wready),
        .video     (video)
    );

endmodule

// ==== verilog/display_timing.sv ====
/*
 * display timing: raster counters with sync levels, data enable
 * and the line and frame strobes
 */
`timescale 1ns/10ps

module display_timing (
    input  logic               clk_100m,
    input  logic               rst_n,
    output bounce_pkg::sync_t  sync
);

    bounce_pkg::coord_t sx;  // horizontal position
    bounce_pkg::coord_t sy;  // vertical position
    logic               line_end;
    logic               frame_end;

    assign line_end  = (sx == bounce_pkg::coord_t'(bounce_pkg::H_TOTAL - 1));
    assign frame_end = line_end && (sy == bounce_pkg::coord_t'(bounce_pkg::V_TOTAL - 1));

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (line_end) begin
            sx <= '0;
            sy <= frame_end ? '0 : sy + 1'b1;  // wrap at bottom
        end else begin
            sx <= sx + 1'b1;
        end
    end

    always_comb begin
        sync.sx    = sx;
        sync.sy    = sy;
        sync.hsync = (sx >= bounce_pkg::coord_t'(bounce_pkg::H_SYNC_START))
                  && (sx <  bounce_pkg::coord_t'(bounce_pkg::H_SYNC_END));
        sync.vsync = (sy >= bounce_pkg::coord_t'(bounce_pkg::V_SYNC_START))
                  && (sy <  bounce_pkg::coord_t'(bounce_pkg::V_SYNC_END));
        sync.de    = (sx < bounce_pkg::coord_t'(bounce_pkg::H_ACTIVE))
                  && (sy < bounce_pkg::coord_t'(bounce_pkg::V_ACTIVE));
        sync.line  = line_end;
        sync.frame = frame_end;
    end

    // counters never leave the raster
    a_raster_in_range: assert property (
        @(posedge clk_100m) disable iff (!rst_n)
        (sx < bounce_pkg::coord_t'(bounce_pkg::H_TOTAL))
        && (sy < bounce_pkg::coord_t'(bounce_pkg::V_TOTAL))
    );

endmodule

// ==== verilog/draw_sequencer.sv ====
/*
 * draw sequencer: starts one square draw per frame
 * once the back buffer accepts writes
 */
`timescale 1ns/10ps

module draw_sequencer (
    input  logic                clk_100m,
    input  logic                rst_n,
    input  logic                frame,
    input  logic                wready,
    input  bounce_pkg::coord_t  pos_x,
    input  bounce_pkg::coord_t  pos_y,
    input  bounce_pkg::cidx_t   fill_cidx,
    input  logic                fill_done,
    output logic                start,
    output bounce_pkg::rect_t   rect,
    output bounce_pkg::cidx_t   cidx,
    output logic                draw_done
);

    typedef enum logic [1:0] {IDLE, INIT, DRAW, DONE} state_t;

    state_t state;

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            state     <= IDLE;
            start     <= 1'b0;
            draw_done <= 1'b0;
        end else begin
            start     <= 1'b0;
            draw_done <= 1'b0;
            case (state)
                IDLE: if (frame) state <= INIT;
                INIT: begin
                    if (wready) begin  // back buffer cleared
                        start <= 1'b1;
                        state <= DRAW;
                    end
                end
                DRAW: if (fill_done) state <= DONE;
                DONE: begin
                    draw_done <= 1'b1;
                    state     <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // square corners and colour, captured with start
    always_ff @(posedge clk_100m) begin
        if (state == INIT && wready) begin
            rect.x0 <= pos_x;
            rect.y0 <= pos_y;
            rect.x1 <= pos_x + bounce_pkg::coord_t'(bounce_pkg::SQ_SIZE);
            rect.y1 <= pos_y + bounce_pkg::coord_t'(bounce_pkg::SQ_SIZE);
            cidx    <= fill_cidx;
        end
    end

endmodule

// ==== verilog/framebuffer.sv ====
/*
 * double-buffered framebuffer: clears the back bank after each swap,
 * reads the front bank in raster order through the palette
 */
`timescale 1ns/10ps

module framebuffer (
    input  logic                 clk_100m,
    input  logic                 rst_n,
    input  bounce_pkg::sync_t    sync,
    input  bounce_pkg::pix_wr_t  wr,
    input  logic                 draw_done,
    output logic                 wready,
    output bounce_pkg::video_t   video
);

    typedef logic [$clog2(bounce_pkg::FB_PIXELS)-1:0] addr_t;

    bounce_pkg::cidx_t bank0 [bounce_pkg::FB_PIXELS];
    bounce_pkg::cidx_t bank1 [bounce_pkg::FB_PIXELS];

    logic              front_sel;  // bank on screen
    logic              ready;      // back bank holds a finished draw
    logic              clearing;
    addr_t             clear_addr;
    logic              mem_we;
    addr_t             mem_addr;
    bounce_pkg::cidx_t mem_data;
    addr_t             rd_addr;
    bounce_pkg::cidx_t rd_cidx;
    bounce_pkg::sync_t sync_d1;    // timing after memory read

    assign wready = !clearing;

    // swap, ready flag and clear counter
    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            front_sel  <= 1'b0;
            ready      <= 1'b0;
            clearing   <= 1'b0;
            clear_addr <= '0;
        end else if (sync.frame && ready) begin
            front_sel  <= !front_sel;
            ready      <= 1'b0;
            clearing   <= 1'b1;
            clear_addr <= '0;
        end else begin
            if (draw_done)
                ready <= 1'b1;
            if (clearing) begin
                if (clear_addr == addr_t'(bounce_pkg::FB_PIXELS - 1))
                    clearing <= 1'b0;
                clear_addr <= clear_addr + 1'b1;
            end
        end
    end

    // back bank write port, clear has priority
    always_comb begin
        mem_we   = clearing || wr.we;
        mem_addr = clearing ? clear_addr
                 : addr_t'(wr.y) * addr_t'(bounce_pkg::FB_WIDTH) + addr_t'(wr.x);
        mem_data = clearing ? bounce_pkg::BG_CIDX : wr.cidx;
    end

    always_ff @(posedge clk_100m) begin
        if (mem_we) begin
            if (front_sel)
                bank0[mem_addr] <= mem_data;
            else
                bank1[mem_addr] <= mem_data;
        end
    end

    assign rd_addr = addr_t'(sync.sy) * addr_t'(bounce_pkg::FB_WIDTH) + addr_t'(sync.sx);

    // stage 1 memory read, stage 2 palette lookup
    always_ff @(posedge clk_100m) begin
        if (!sync.de)
            rd_cidx <= bounce_pkg::BG_CIDX;  // address out of range in blanking
        else if (front_sel)
            rd_cidx <= bank1[rd_addr];
        else
            rd_cidx <= bank0[rd_addr];
        {video.red, video.green, video.blue} <= bounce_pkg::PALETTE[rd_cidx];
    end

    // timing delayed to match the two read stages
    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            sync_d1     <= '0;
            video.hsync <= 1'b0;
            video.vsync <= 1'b0;
            video.de    <= 1'b0;
            video.frame <= 1'b0;
        end else begin
            sync_d1     <= sync;
            video.hsync <= sync_d1.hsync;
            video.vsync <= sync_d1.vsync;
            video.de    <= sync_d1.de;
            video.frame <= sync_d1.frame;
        end
    end

    // the sequencer only draws once the clear is finished
    a_no_write_in_clear: assert property (
        @(posedge clk_100m) disable iff (!rst_n)
        wr.we |-> !clearing
    );

endmodule

// ==== verilog/rect_fill.sv ====
/*
 * rectangle fill engine: walks the rectangle row by row and
 * issues one pixel write per cycle
 */
`timescale 1ns/10ps

module rect_fill (
    input  logic                 clk_100m,
    input  logic                 rst_n,
    input  logic                 start,
    input  bounce_pkg::rect_t    rect,
    input  bounce_pkg::cidx_t    cidx,
    output bounce_pkg::pix_wr_t  wr,
    output logic                 done
);

    bounce_pkg::rect_t  r;      // latched at start
    bounce_pkg::cidx_t  colour;
    bounce_pkg::coord_t cur_x;
    bounce_pkg::coord_t cur_y;
    logic               busy;
    logic               row_end;
    logic               last_pix;

    assign row_end  = (cur_x == r.x1 - 1'b1);
    assign last_pix = row_end && (cur_y == r.y1 - 1'b1);

    // control state
    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= busy && last_pix;  // one cycle after last write
            if (start && !busy)
                busy <= 1'b1;
            else if (busy && last_pix)
                busy <= 1'b0;
        end
    end

    // cursor and payload
    always_ff @(posedge clk_100m) begin
        if (start && !busy) begin
            r      <= rect;
            colour <= cidx;
            cur_x  <= rect.x0;
            cur_y  <= rect.y0;
        end else if (busy) begin
            if (row_end) begin
                cur_x <= r.x0;  // back to left side
                cur_y <= cur_y + 1'b1;
            end else begin
                cur_x <= cur_x + 1'b1;
            end
        end
    end

    always_comb begin
        wr.we   = busy;
        wr.x    = cur_x;
        wr.y    = cur_y;
        wr.cidx = colour;
    end

    // writes stay inside the rectangle the sequencer holds
    a_write_in_rect: assert property (
        @(posedge clk_100m) disable iff (!rst_n)
        wr.we |-> (wr.x >= rect.x0) && (wr.x < rect.x1)
               && (wr.y >= rect.y0) && (wr.y < rect.y1)
    );

endmodule

// ==== verilog/square_motion.sv ====
/*
 * square motion: moves the square once per frame and
 * reverses direction at the framebuffer edges
 */
`timescale 1ns/10ps

module square_motion (
    input  logic                clk_100m,
    input  logic                rst_n,
    input  logic                frame,
    input  bounce_pkg::speed_t  speed,
    output bounce_pkg::coord_t  pos_x,
    output bounce_pkg::coord_t  pos_y
);

    bounce_pkg::coord_t spd;  // speed widened to coordinate width
    logic               dir_x;  // 1 moves left
    logic               dir_y;  // 1 moves up

    assign spd = bounce_pkg::coord_t'(speed);

    // bounce rule for one axis, returns {direction, new position}
    function automatic logic [8:0] step(bounce_pkg::coord_t pos, logic dir,
                                        bounce_pkg::coord_t limit,
                                        bounce_pkg::coord_t s);
        if (pos >= limit - s)
            return {1'b1, pos - s};  // far edge
        else if (pos < s)
            return {1'b0, pos + s};  // near edge
        else if (dir)
            return {1'b1, pos - s};
        else
            return {1'b0, pos + s};
    endfunction

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            pos_x <= '0;
            pos_y <= '0;
            dir_x <= 1'b0;  // right
            dir_y <= 1'b0;  // down
        end else if (frame) begin
            {dir_x, pos_x} <= step(pos_x, dir_x,
                bounce_pkg::coord_t'(bounce_pkg::FB_WIDTH - bounce_pkg::SQ_SIZE), spd);
            {dir_y, pos_y} <= step(pos_y, dir_y,
                bounce_pkg::coord_t'(bounce_pkg::FB_HEIGHT - bounce_pkg::SQ_SIZE), spd);
        end
    end

    // square never leaves the framebuffer
    a_pos_in_range: assert property (
        @(posedge clk_100m) disable iff (!rst_n)
        (pos_x <= bounce_pkg::coord_t'(bounce_pkg::FB_WIDTH - bounce_pkg::SQ_SIZE))
        && (pos_y <= bounce_pkg::coord_t'(bounce_pkg::FB_HEIGHT - bounce_pkg::SQ_SIZE))
    );

endmodule
